// File: camera_mask_defines.svh
`ifndef CAMERA_MASK_DEFINES_SVH
`define CAMERA_MASK_DEFINES_SVH

// ==========================================================================
// raster geometry, 1280x720 active inside a 1650x750 total
// ==========================================================================
`define CM_H_ACTIVE 1280
`define CM_V_ACTIVE 720
`define CM_H_TOTAL 1650
`define CM_V_TOTAL 750

// sync pulses, active high, start inclusive and end exclusive
`define CM_H_SYNC_START 1390
`define CM_H_SYNC_END 1430
`define CM_V_SYNC_START 725
`define CM_V_SYNC_END 730

// ==========================================================================
// game window and green screen bounds
// ==========================================================================
// margins from the left, right and bottom edges of the active area
`define CM_WIN_LEFT 65
`define CM_WIN_RIGHT 85
`define CM_WIN_BOTTOM 85

// offset-binary chroma upper bounds for green screen
`define CM_CR_UPPER 8'h90
`define CM_CB_UPPER 8'h90

// shown when the pixel queue runs dry during active draw
`define CM_FILL_565 16'h2277

// queue depth, also the credit count the source starts with
`define CM_PIX_FIFO_DEPTH 8

`endif

// File: camera_mask_pkg.sv
package camera_mask_pkg;

  // frame buffer pixel, 5/6/5 packed
  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } rgb565_t;

  // full 8 bit per channel pixel, red in the top byte
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb888_t;

  // raster coordinates
  typedef logic [10:0] hcount_t;
  typedef logic [9:0] vcount_t;

  // what the output picture shows
  typedef enum logic [1:0] {
    mode_camera = 2'b00,
    mode_luma = 2'b01,
    mode_mask = 2'b10,
    mode_camera_magenta = 2'b11
  } display_mode_t;

endpackage

// File: centroid_tracker.sv
`timescale 1ns/1ns

module centroid_tracker (
  input  logic                     clk_pixel,
  input  logic                     recent_reset,
  video_timing_if.sink             tim_i,
  input  logic                     player_i,
  output camera_mask_pkg::hcount_t com_x_o,
  output camera_mask_pkg::vcount_t com_y_o,
  output logic                     com_valid_o
);

  // sum and count widths cover a full 1280x720 frame
  localparam int SW = 32;
  localparam int CW = 20;

  logic                     hit;
  logic [SW-1:0]            acc_x;
  logic [SW-1:0]            acc_y;
  logic [CW-1:0]            acc_n;
  logic                     busy;
  logic                     phase_y;
  logic [5:0]               step;
  logic [SW-1:0]            quo;
  logic [CW-1:0]            rem;
  logic [CW-1:0]            divisor;
  logic [SW-1:0]            pend_y;
  camera_mask_pkg::hcount_t res_x;
  logic [CW:0]              rem_shift;
  logic [CW+1:0]            trial;
  logic [CW-1:0]            rem_next;
  logic [SW-1:0]            quo_next;

  assign hit = tim_i.active && player_i;

  // ========================================================================
  // per frame sums, restarted on the frame marker
  // ========================================================================
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      acc_x <= '0;
      acc_y <= '0;
      acc_n <= '0;
    end else if (tim_i.new_frame) begin
      // pixel (0,0) already belongs to the new frame
      acc_x <= hit ? SW'(tim_i.hcount) : '0;
      acc_y <= hit ? SW'(tim_i.vcount) : '0;
      acc_n <= hit ? CW'(1) : '0;
    end else if (hit) begin
      acc_x <= acc_x + SW'(tim_i.hcount);
      acc_y <= acc_y + SW'(tim_i.vcount);
      acc_n <= acc_n + 1'b1;
    end
  end

  // ========================================================================
  // restoring divider, x first then y on the same hardware
  // ========================================================================
  // bring down the next dividend bit and try to subtract
  assign rem_shift = {rem, quo[SW-1]};
  assign trial = {1'b0, rem_shift} - {2'b00, divisor};

  always_comb begin
    if (trial[CW+1]) begin
      // borrow, restore
      rem_next = rem_shift[CW-1:0];
      quo_next = {quo[SW-2:0], 1'b0};
    end else begin
      rem_next = trial[CW-1:0];
      quo_next = {quo[SW-2:0], 1'b1};
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      busy <= 1'b0;
      phase_y <= 1'b0;
      step <= '0;
      com_x_o <= '0;
      com_y_o <= '0;
      com_valid_o <= 1'b0;
    end else begin
      com_valid_o <= 1'b0;
      // empty frame leaves the last centre in place
      if (tim_i.new_frame && (acc_n != '0)) begin
        busy <= 1'b1;
        phase_y <= 1'b0;
        step <= '0;
        quo <= acc_x;
        rem <= '0;
        divisor <= acc_n;
        pend_y <= acc_y;
      end else if (busy) begin
        quo <= quo_next;
        rem <= rem_next;
        step <= step + 1'b1;
        if (step == SW - 1) begin
          if (!phase_y) begin
            // x done, load the y sum
            res_x <= quo_next[10:0];
            phase_y <= 1'b1;
            quo <= pend_y;
            rem <= '0;
            step <= '0;
          end else begin
            busy <= 1'b0;
            com_x_o <= res_x;
            com_y_o <= quo_next[9:0];
            com_valid_o <= 1'b1;
          end
        end
      end
    end
  end

endmodule

// File: chroma_mask.sv
`timescale 1ns/1ns
`include "camera_mask_defines.svh"

module chroma_mask #(
  parameter int H_ACTIVE = `CM_H_ACTIVE,
  parameter int V_ACTIVE = `CM_V_ACTIVE,
  parameter int WIN_LEFT = `CM_WIN_LEFT,
  parameter int WIN_RIGHT = `CM_WIN_RIGHT,
  parameter int WIN_BOTTOM = `CM_WIN_BOTTOM
) (
  input  logic                     clk_pixel,
  input  logic                     recent_reset,
  video_timing_if.sink             tim_i,
  video_timing_if.src              tim_o,
  input  logic                     pix_valid_i,
  input  camera_mask_pkg::rgb565_t pix_data_i,
  output logic                     credit_o,
  output camera_mask_pkg::rgb888_t cam_rgb_o,
  output logic [7:0]               luma_o,
  output logic                     player_o
);

  localparam int LAT = 4;

  // raster fields carried alongside the pixel
  typedef struct packed {
    camera_mask_pkg::hcount_t hcount;
    camera_mask_pkg::vcount_t vcount;
    logic hsync;
    logic vsync;
    logic active;
    logic new_frame;
  } raster_t;

  logic                     pop;
  logic                     empty;
  camera_mask_pkg::rgb565_t pix_head;
  camera_mask_pkg::rgb565_t pix_sel;
  raster_t                  ras [LAT];
  camera_mask_pkg::rgb888_t rgb_s1;
  camera_mask_pkg::rgb888_t rgb_s2;
  camera_mask_pkg::rgb888_t rgb_s3;
  logic [15:0]              y_r, y_g, y_b;
  logic [15:0]              cr_r, cr_g, cr_b;
  logic [15:0]              cb_r, cb_g, cb_b;
  logic [15:0]              y_sum;
  logic signed [17:0]       cr_sum;
  logic signed [17:0]       cb_sum;
  logic [7:0]               cr_off;
  logic [7:0]               cb_off;
  logic                     in_window;

  pixel_credit_fifo u_fifo (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .pix_valid_i  (pix_valid_i),
    .pix_data_i   (pix_data_i),
    .pop_i        (pop),
    .pix_o        (pix_head),
    .empty_o      (empty),
    .credit_o     (credit_o)
  );

  // ========================================================================
  // cycle 1: pop on active draw, fill colour when the queue is dry
  // ========================================================================
  assign pop = tim_i.active && !empty;
  assign pix_sel = empty ? camera_mask_pkg::rgb565_t'(`CM_FILL_565) : pix_head;

  // zero fill the low bits of each channel
  always_ff @(posedge clk_pixel) begin
    rgb_s1 <= {pix_sel.r, 3'b000, pix_sel.g, 2'b00, pix_sel.b, 3'b000};
    rgb_s2 <= rgb_s1;
    rgb_s3 <= rgb_s2;
    cam_rgb_o <= rgb_s3;
  end

  // ========================================================================
  // cycles 2 to 4: BT.601 in 8 bit fixed point, then threshold
  // ========================================================================
  // cycle 2: coefficient products, all magnitudes
  always_ff @(posedge clk_pixel) begin
    y_r <= 8'd66 * rgb_s1.r;
    y_g <= 8'd129 * rgb_s1.g;
    y_b <= 8'd25 * rgb_s1.b;
    cr_r <= 8'd112 * rgb_s1.r;
    cr_g <= 8'd94 * rgb_s1.g;
    cr_b <= 8'd18 * rgb_s1.b;
    cb_r <= 8'd38 * rgb_s1.r;
    cb_g <= 8'd74 * rgb_s1.g;
    cb_b <= 8'd112 * rgb_s1.b;
  end

  // cycle 3: sums with signs applied, chroma can go negative
  always_ff @(posedge clk_pixel) begin
    y_sum <= y_r + y_g + y_b;
    cr_sum <= $signed({2'b00, cr_r}) - $signed({2'b00, cr_g}) - $signed({2'b00, cr_b});
    cb_sum <= $signed({2'b00, cb_b}) - $signed({2'b00, cb_r}) - $signed({2'b00, cb_g});
  end

  // signed chroma >> 8, top bit flipped gives offset binary
  assign cr_off = {~cr_sum[15], cr_sum[14:8]};
  assign cb_off = {~cb_sum[15], cb_sum[14:8]};

  // window test on the raster of the same stage
  assign in_window = (ras[2].hcount >= WIN_LEFT) &&
                     (ras[2].hcount <= H_ACTIVE - 1 - WIN_RIGHT) &&
                     (ras[2].vcount <= V_ACTIVE - 1 - WIN_BOTTOM);

  // cycle 4: luma with its +16 offset, player = not green screen and in window
  always_ff @(posedge clk_pixel) begin
    luma_o <= y_sum[15:8] + 8'd16;
    player_o <= in_window && !((cr_off <= `CM_CR_UPPER) && (cb_off <= `CM_CB_UPPER));
  end

  // raster delayed in step with the pixel
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      for (int i = 0; i < LAT; i++) begin
        ras[i] <= '0;
      end
    end else begin
      ras[0] <= '{tim_i.hcount, tim_i.vcount, tim_i.hsync, tim_i.vsync,
                  tim_i.active, tim_i.new_frame};
      for (int i = 1; i < LAT; i++) begin
        ras[i] <= ras[i-1];
      end
    end
  end

  assign tim_o.hcount = ras[LAT-1].hcount;
  assign tim_o.vcount = ras[LAT-1].vcount;
  assign tim_o.hsync = ras[LAT-1].hsync;
  assign tim_o.vsync = ras[LAT-1].vsync;
  assign tim_o.active = ras[LAT-1].active;
  assign tim_o.new_frame = ras[LAT-1].new_frame;

endmodule

// File: overlay_mux.sv
`timescale 1ns/1ns

module overlay_mux (
  input  logic                           clk_pixel,
  input  logic                           recent_reset,
  video_timing_if.sink                   tim_i,
  input  camera_mask_pkg::display_mode_t mode_i,
  input  logic                           crosshair_en_i,
  input  camera_mask_pkg::rgb888_t       cam_rgb_i,
  input  logic [7:0]                     luma_i,
  input  logic                           player_i,
  input  camera_mask_pkg::hcount_t       com_x_i,
  input  camera_mask_pkg::vcount_t       com_y_i,
  input  logic                           com_valid_i,
  output camera_mask_pkg::rgb888_t       rgb_o,
  output logic                           de_o,
  output logic                           hsync_o,
  output logic                           vsync_o
);

  logic                     com_seen;
  logic                     on_cross;
  camera_mask_pkg::rgb888_t pic;

  // no crosshair until a centre has been computed
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      com_seen <= 1'b0;
    end else if (com_valid_i) begin
      com_seen <= 1'b1;
    end
  end

  // on the centre's row or column
  assign on_cross = crosshair_en_i && com_seen &&
                    ((tim_i.hcount == com_x_i) || (tim_i.vcount == com_y_i));

  // ========================================================================
  // picture select, crosshair on top, black in blanking
  // ========================================================================
  always_comb begin
    case (mode_i)
      camera_mask_pkg::mode_luma: pic = {luma_i, luma_i, luma_i};
      camera_mask_pkg::mode_mask: pic = player_i ? 24'hff_ffff : 24'h00_0000;
      camera_mask_pkg::mode_camera_magenta: pic = player_i ? 24'hff_00ff : cam_rgb_i;
      default: pic = cam_rgb_i;
    endcase
    if (on_cross) begin
      pic = 24'hff_0000;
    end
    if (!tim_i.active) begin
      pic = '0;
    end
  end

  always_ff @(posedge clk_pixel) begin
    rgb_o <= pic;
  end

  // sync and enable share the pixel's one cycle register
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      de_o <= 1'b0;
      hsync_o <= 1'b0;
      vsync_o <= 1'b0;
    end else begin
      de_o <= tim_i.active;
      hsync_o <= tim_i.hsync;
      vsync_o <= tim_i.vsync;
    end
  end

endmodule

// File: pixel_credit_fifo.sv
`timescale 1ns/1ns
`include "camera_mask_defines.svh"

module pixel_credit_fifo (
  input  logic                     clk_pixel,
  input  logic                     recent_reset,
  input  logic                     pix_valid_i,
  input  camera_mask_pkg::rgb565_t pix_data_i,
  input  logic                     pop_i,
  output camera_mask_pkg::rgb565_t pix_o,
  output logic                     empty_o,
  output logic                     credit_o
);

  localparam int DEPTH = `CM_PIX_FIFO_DEPTH;
  localparam int AW = $clog2(DEPTH);

  camera_mask_pkg::rgb565_t mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          full;
  logic          push;
  logic          do_pop;

  assign full = (count == DEPTH);
  assign empty_o = (count == '0);
  assign push = pix_valid_i && !full;
  assign do_pop = pop_i && !empty_o;

  // head of queue is visible without a read cycle
  assign pix_o = mem[rd_ptr];

  always_ff @(posedge clk_pixel) begin
    if (push) begin
      mem[wr_ptr] <= pix_data_i;
    end
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      credit_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + {{AW{1'b0}}, push} - {{AW{1'b0}}, do_pop};
      // one credit back to the source per consumed pixel
      credit_o <= do_pop;
    end
  end

  // the source only sends while it holds a credit, so the queue never overflows
  a_no_push_when_full: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    full |-> !pix_valid_i)
    else $error("pixel pushed into a full queue, credit protocol broken");

endmodule

// File: player_view_top.sv
`timescale 1ns/1ns
`include "camera_mask_defines.svh"

module player_view_top #(
  parameter int H_ACTIVE = `CM_H_ACTIVE,
  parameter int V_ACTIVE = `CM_V_ACTIVE,
  parameter int H_TOTAL = `CM_H_TOTAL,
  parameter int V_TOTAL = `CM_V_TOTAL,
  parameter int H_SYNC_START = `CM_H_SYNC_START,
  parameter int H_SYNC_END = `CM_H_SYNC_END,
  parameter int V_SYNC_START = `CM_V_SYNC_START,
  parameter int V_SYNC_END = `CM_V_SYNC_END,
  parameter int WIN_LEFT = `CM_WIN_LEFT,
  parameter int WIN_RIGHT = `CM_WIN_RIGHT,
  parameter int WIN_BOTTOM = `CM_WIN_BOTTOM
) (
  input  logic        clk_pixel,
  input  logic        recent_reset,
  input  logic        pix_valid_i,
  input  logic [15:0] pix_data_i,
  input  logic [1:0]  mode_i,
  input  logic        crosshair_en_i,
  output logic        credit_o,
  output logic [23:0] rgb_o,
  output logic        de_o,
  output logic        hsync_o,
  output logic        vsync_o,
  output logic [10:0] com_x_o,
  output logic [9:0]  com_y_o,
  output logic        com_valid_o
);

  // raster at the counters, and 4 cycles later beside the converted pixel
  video_timing_if tim_raw ();
  video_timing_if tim_dly ();

  camera_mask_pkg::rgb888_t cam_rgb;
  logic [7:0]               luma;
  logic                     player;

  video_timing #(
    .H_ACTIVE     (H_ACTIVE),
    .V_ACTIVE     (V_ACTIVE),
    .H_TOTAL      (H_TOTAL),
    .V_TOTAL      (V_TOTAL),
    .H_SYNC_START (H_SYNC_START),
    .H_SYNC_END   (H_SYNC_END),
    .V_SYNC_START (V_SYNC_START),
    .V_SYNC_END   (V_SYNC_END)
  ) u_timing (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .tim_o        (tim_raw)
  );

  chroma_mask #(
    .H_ACTIVE   (H_ACTIVE),
    .V_ACTIVE   (V_ACTIVE),
    .WIN_LEFT   (WIN_LEFT),
    .WIN_RIGHT  (WIN_RIGHT),
    .WIN_BOTTOM (WIN_BOTTOM)
  ) u_mask (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .tim_i        (tim_raw),
    .tim_o        (tim_dly),
    .pix_valid_i  (pix_valid_i),
    .pix_data_i   (pix_data_i),
    .credit_o     (credit_o),
    .cam_rgb_o    (cam_rgb),
    .luma_o       (luma),
    .player_o     (player)
  );

  centroid_tracker u_centroid (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .tim_i        (tim_dly),
    .player_i     (player),
    .com_x_o      (com_x_o),
    .com_y_o      (com_y_o),
    .com_valid_o  (com_valid_o)
  );

  overlay_mux u_overlay (
    .clk_pixel      (clk_pixel),
    .recent_reset   (recent_reset),
    .tim_i          (tim_dly),
    .mode_i         (camera_mask_pkg::display_mode_t'(mode_i)),
    .crosshair_en_i (crosshair_en_i),
    .cam_rgb_i      (cam_rgb),
    .luma_i         (luma),
    .player_i       (player),
    .com_x_i        (com_x_o),
    .com_y_i        (com_y_o),
    .com_valid_i    (com_valid_o),
    .rgb_o          (rgb_o),
    .de_o           (de_o),
    .hsync_o        (hsync_o),
    .vsync_o        (vsync_o)
  );

endmodule

// File: src.f
+incdir+.
camera_mask_pkg.sv
video_timing_if.sv
video_timing.sv
pixel_credit_fifo.sv
chroma_mask.sv
centroid_tracker.sv
overlay_mux.sv
player_view_top.sv
tb_player_view.sv

// File: tb_player_view.sv
`timescale 1ns/1ns
`include "camera_mask_defines.svh"

module tb_player_view;

  // small raster so a whole frame is only 72 cycles
  localparam int H_ACT = 8;
  localparam int V_ACT = 4;
  localparam int H_TOT = 12;
  localparam int V_TOT = 6;
  localparam int H_SYNC_S = 9;
  localparam int H_SYNC_E = 10;
  localparam int V_SYNC_S = 4;
  localparam int V_SYNC_E = 5;
  // raster counters to de_o and syncs, 4 stages of colour conversion and 1 of overlay
  localparam int OUT_LAG = 5;
  localparam int CLK_NS = 10;
  localparam int RESET_CYCLES = 10;
  localparam int N_PIX = H_ACT * V_ACT;
  // frame 0 shows the fill colour, frames 1 to 4 carry streamed pixels
  localparam int N_FRAMES = 5;
  localparam int N_SENT = (N_FRAMES - 1) * N_PIX;
  localparam int WATCHDOG_NS = ((N_FRAMES + 2) * V_TOT * H_TOT + RESET_CYCLES) * CLK_NS + 1000;

  logic        clk_pixel;
  logic        recent_reset;
  logic        pix_valid_i;
  logic [15:0] pix_data_i;
  logic [1:0]  mode_i;
  logic        crosshair_en_i;
  logic        credit_o;
  logic [23:0] rgb_o;
  logic        de_o;
  logic        hsync_o;
  logic        vsync_o;
  logic [10:0] com_x_o;
  logic [9:0]  com_y_o;
  logic        com_valid_o;

  // per pixel: rgb565, luma, mask; then centre x and y
  logic [15:0] stim [0:3*N_PIX+1];

  integer seed = 90;
  int errors = 0;
  int checks = 0;
  int credits = `CM_PIX_FIFO_DEPTH;
  int credit_pulses = 0;
  int sent = 0;
  int shown = 0;
  int com_count = 0;

  player_view_top #(
    .H_ACTIVE     (H_ACT),
    .V_ACTIVE     (V_ACT),
    .H_TOTAL      (H_TOT),
    .V_TOTAL      (V_TOT),
    .H_SYNC_START (H_SYNC_S),
    .H_SYNC_END   (H_SYNC_E),
    .V_SYNC_START (V_SYNC_S),
    .V_SYNC_END   (V_SYNC_E),
    .WIN_LEFT     (1),
    .WIN_RIGHT    (1),
    .WIN_BOTTOM   (1)
  ) u_dut (
    .clk_pixel      (clk_pixel),
    .recent_reset   (recent_reset),
    .pix_valid_i    (pix_valid_i),
    .pix_data_i     (pix_data_i),
    .mode_i         (mode_i),
    .crosshair_en_i (crosshair_en_i),
    .credit_o       (credit_o),
    .rgb_o          (rgb_o),
    .de_o           (de_o),
    .hsync_o        (hsync_o),
    .vsync_o        (vsync_o),
    .com_x_o        (com_x_o),
    .com_y_o        (com_y_o),
    .com_valid_o    (com_valid_o)
  );

  // ==========================================================================
  // reference model helpers
  // ==========================================================================
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic check_outputs_idle(input string name);
    check_value({name, " de_o"}, 0, de_o);
    check_value({name, " credit_o"}, 0, credit_o);
    check_value({name, " com_valid_o"}, 0, com_valid_o);
    check_value({name, " com_x_o"}, 0, com_x_o);
    check_value({name, " com_y_o"}, 0, com_y_o);
  endtask

  // low bits of each channel are zero filled
  function automatic logic [23:0] expand_565(input logic [15:0] p);
    return {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
  endfunction

  function automatic logic [1:0] mode_for_frame(input int frame);
    case (frame)
      2: return 2'b01;
      3: return 2'b10;
      default: return 2'b00;
    endcase
  endfunction

  // on in frame 0 too, where no centre exists yet
  function automatic logic crosshair_for_frame(input int frame);
    return (frame == 0) || (frame == N_FRAMES - 1);
  endfunction

  function automatic logic [23:0] expected_rgb(input int frame, input int n);
    logic [23:0] rgb;
    logic [7:0]  luma;
    int          x;
    int          y;
    luma = stim[3*n+1][7:0];
    x = n % H_ACT;
    y = n / H_ACT;
    // queue is empty while frame 0 draws, and there is no centre yet
    if (frame == 0) begin
      return expand_565(`CM_FILL_565);
    end
    case (mode_for_frame(frame))
      2'b01: rgb = {luma, luma, luma};
      2'b10: rgb = stim[3*n+2][0] ? 24'hff_ffff : 24'h00_0000;
      default: rgb = expand_565(stim[3*n]);
    endcase
    if (crosshair_for_frame(frame) && (x == stim[3*N_PIX] || y == stim[3*N_PIX+1])) begin
      rgb = 24'hff_0000;
    end
    return rgb;
  endfunction

  // ==========================================================================
  // clock, credit source and monitors
  // ==========================================================================
  initial begin : clock_gen
    clk_pixel = 1'b0;
    forever #(CLK_NS / 2) clk_pixel = ~clk_pixel;
  end

  // random gaps only while few credits are held, so active draw never starves
  initial begin : credit_source
    int   gap;
    logic streaming;
    gap = 0;
    streaming = 1'b0;
    forever begin
      @(negedge clk_pixel);
      pix_valid_i = 1'b0;
      if (credit_o === 1'b1) begin
        credits++;
        credit_pulses++;
      end
      // first vertical sync comes after the fill frame has been drawn
      if (vsync_o === 1'b1) begin
        streaming = 1'b1;
      end
      if (gap > 0) begin
        gap--;
      end
      if (streaming && sent < N_SENT && credits > 0 && (gap == 0 || credits > 2)) begin
        pix_valid_i = 1'b1;
        pix_data_i = stim[3*(sent % N_PIX)];
        credits--;
        sent++;
        gap = $random(seed) & 3;
      end
    end
  end

  // de_o and the syncs follow the raster that starts at (0,0) when reset drops
  initial begin : raster_monitor
    int cycles;
    int pos;
    int h;
    int v;
    cycles = 0;
    forever begin
      @(posedge clk_pixel);
      if (recent_reset === 1'b0) begin
        cycles++;
      end
      @(negedge clk_pixel);
      if (cycles >= OUT_LAG) begin
        pos = cycles - OUT_LAG;
        h = pos % H_TOT;
        v = (pos / H_TOT) % V_TOT;
        check_value($sformatf("de_o at %0d,%0d", h, v), (h < H_ACT) && (v < V_ACT), de_o);
        check_value($sformatf("hsync_o at %0d,%0d", h, v),
                    (h >= H_SYNC_S) && (h < H_SYNC_E), hsync_o);
        check_value($sformatf("vsync_o at %0d,%0d", h, v),
                    (v >= V_SYNC_S) && (v < V_SYNC_E), vsync_o);
      end
    end
  end

  // n-th de_o cycle of a frame is the n-th pixel of the raster
  initial begin : pixel_monitor
    int frame;
    int n;
    forever begin
      @(negedge clk_pixel);
      if (de_o === 1'b1 && shown < N_FRAMES * N_PIX) begin
        frame = shown / N_PIX;
        n = shown % N_PIX;
        check_value($sformatf("rgb frame %0d pixel %0d", frame, n), expected_rgb(frame, n),
                    rgb_o);
        shown++;
        // next frame's settings go in while the raster is blanked
        if (n == N_PIX - 1 && frame + 1 < N_FRAMES) begin
          mode_i = mode_for_frame(frame + 1);
          crosshair_en_i = crosshair_for_frame(frame + 1);
        end
      end
    end
  end

  initial begin : centre_monitor
    forever begin
      @(negedge clk_pixel);
      if (com_valid_o === 1'b1) begin
        // pulse 0 belongs to the fill frame
        if (com_count > 0) begin
          check_value($sformatf("centre x frame %0d", com_count), stim[3*N_PIX], com_x_o);
          check_value($sformatf("centre y frame %0d", com_count), stim[3*N_PIX+1], com_y_o);
        end
        com_count++;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: only %0d of %0d centre pulses after %0d ns, %0d errors so far",
             com_count, N_FRAMES, WATCHDOG_NS, errors);
    $display("=== FAIL ===");
    $finish;
  end

  // ==========================================================================
  // main sequence
  // ==========================================================================
  initial begin : main
    pix_valid_i = 1'b0;
    pix_data_i = '0;
    mode_i = mode_for_frame(0);
    crosshair_en_i = crosshair_for_frame(0);
    recent_reset = 1'b1;
    $readmemh("tb_player_view_stimulus.txt", stim);
    if (stim[3*N_PIX+1] === 16'hxxxx) begin
      errors++;
      $display("the stimulus file could not be read completely");
    end
    repeat (RESET_CYCLES) begin
      @(negedge clk_pixel);
      check_outputs_idle("during reset");
    end
    recent_reset = 1'b0;
    // pipeline is still filling, de_o rises on the fifth cycle
    repeat (4) begin
      @(negedge clk_pixel);
      check_outputs_idle("after reset");
    end
    wait (com_count == N_FRAMES);
    repeat (10) @(negedge clk_pixel);
    check_value("pixels sent", N_SENT, sent);
    check_value("credit pulses", N_SENT, credit_pulses);
    check_value("credits held at end", `CM_PIX_FIFO_DEPTH, credits);
    check_value("pixels checked", N_FRAMES * N_PIX, shown);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: tb_player_view_stimulus.txt
// columns: rgb565 pixel, expected luma, expected mask bit
// 32 pixels in raster order, 8 per line; last line holds centre x and y
// line 0
f800 4f 0
07e0 8e 0
07e0 8e 0
07e0 8e 0
001f 28 1
07e0 8e 0
07e0 8e 0
001f 28 0
// line 1
07e0 8e 0
07e0 8e 0
ffff e7 0
f800 4f 1
2277 50 1
8410 7e 0
001f 28 1
f800 4f 0
// line 2
001f 28 0
0000 10 0
07e0 8e 0
f81f 68 1
f800 4f 1
2277 50 1
001f 28 1
07e0 8e 0
// line 3, below the game window
f800 4f 0
001f 28 0
2277 50 0
f81f 68 0
07e0 8e 0
ffff e7 0
0000 10 0
8410 7e 0
// centre x and y
0004 0001

// File: video_timing.sv
`timescale 1ns/1ns
`include "camera_mask_defines.svh"

module video_timing #(
  parameter int H_ACTIVE = `CM_H_ACTIVE,
  parameter int V_ACTIVE = `CM_V_ACTIVE,
  parameter int H_TOTAL = `CM_H_TOTAL,
  parameter int V_TOTAL = `CM_V_TOTAL,
  parameter int H_SYNC_START = `CM_H_SYNC_START,
  parameter int H_SYNC_END = `CM_H_SYNC_END,
  parameter int V_SYNC_START = `CM_V_SYNC_START,
  parameter int V_SYNC_END = `CM_V_SYNC_END
) (
  input  logic        clk_pixel,
  input  logic        recent_reset,
  video_timing_if.src tim_o
);

  camera_mask_pkg::hcount_t hcount;
  camera_mask_pkg::vcount_t vcount;

  // horizontal counter runs every cycle, vertical steps at end of line
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      hcount <= '0;
      vcount <= '0;
    end else if (hcount == H_TOTAL - 1) begin
      hcount <= '0;
      // last line wraps back to the top
      vcount <= (vcount == V_TOTAL - 1) ? '0 : vcount + 1'b1;
    end else begin
      hcount <= hcount + 1'b1;
    end
  end

  // flags decoded straight from the counters, so they line up with them
  assign tim_o.hcount = hcount;
  assign tim_o.vcount = vcount;
  assign tim_o.hsync = (hcount >= H_SYNC_START) && (hcount < H_SYNC_END);
  assign tim_o.vsync = (vcount >= V_SYNC_START) && (vcount < V_SYNC_END);
  assign tim_o.active = (hcount < H_ACTIVE) && (vcount < V_ACTIVE);
  assign tim_o.new_frame = (hcount == '0) && (vcount == '0);

  // position stays inside the total raster
  a_raster_range: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    (hcount < H_TOTAL) && (vcount < V_TOTAL))
    else $error("raster position out of range");

endmodule

// File: video_timing_if.sv
`timescale 1ns/1ns

interface video_timing_if;

  // raster position of the pixel this bundle belongs to
  camera_mask_pkg::hcount_t hcount;
  camera_mask_pkg::vcount_t vcount;

  // sync pulses, active high
  logic hsync;
  logic vsync;

  // position is inside the visible area
  logic active;

  // single cycle marker at (0,0)
  logic new_frame;

  modport src (output hcount, vcount, hsync, vsync, active, new_frame);
  modport sink (input hcount, vcount, hsync, vsync, active, new_frame);

endinterface
